//--- common/soc_config.svh
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

// Upper half-word of the CLINT address region
`define CLINT_BASE_HI 16'h0200

// Clock cycles per mtime tick
`define MTIME_DIV 4

`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`define AXI_ADDR_BURST_INCR 2'b01

`endif

//--- common/soc_pkg.sv
package soc_pkg;

	// Region view of an address
	typedef struct packed {
		logic [15:0] base;
		logic [15:0] offset;
	} addr_fields_t;

	typedef union packed {
		logic [31:0] raw;
		addr_fields_t f;
	} addr_u;

	typedef struct packed {
		addr_u addr;
		logic write;
		logic [31:0] wdata;
		logic [3:0] wstrb;
		logic [2:0] size;
	} cpu_req_t;

	typedef struct packed {
		logic [31:0] rdata;
		logic [1:0] resp;
	} cpu_rsp_t;

	typedef struct packed {
		addr_u addr;
		logic [7:0] len;
		logic [2:0] size;
	} ar_t;

	typedef ar_t aw_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0] strb;
		logic last;
	} w_t;

	typedef struct packed {
		logic [31:0] data;
		logic [1:0] resp;
		logic last;
	} r_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_t;

endpackage

//--- axi_ctl/axi_ctl.sv
module axi_ctl import soc_pkg::*; (
	input  logic     clock,
	input  logic     rst_n_i,
	input  logic     inst_req_i,
	input  cpu_req_t inst_req_data_i,
	output logic     inst_ack_o,
	output cpu_rsp_t inst_rsp_o,
	input  logic     data_req_i,
	input  cpu_req_t data_req_data_i,
	output logic     data_ack_o,
	output cpu_rsp_t data_rsp_o,
	output logic     ar_valid_o,
	input  logic     ar_ready_i,
	output ar_t      ar_o,
	input  logic     r_valid_i,
	output logic     r_ready_o,
	input  r_t       r_i,
	output logic     aw_valid_o,
	input  logic     aw_ready_i,
	output aw_t      aw_o,
	output logic     w_valid_o,
	input  logic     w_ready_i,
	output w_t       w_o,
	input  logic     b_valid_i,
	output logic     b_ready_o,
	input  b_t       b_i
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ADDR,
		ST_RESP,
		ST_DONE
	} state_e;

	state_e state_q;
	logic grant_data_q;
	logic aw_done_q;
	logic w_done_q;

	cpu_req_t sel_req;
	logic sel_req_in;
	logic is_write;
	logic ar_fire;
	logic aw_fire;
	logic w_fire;
	logic resp_fire;
	cpu_rsp_t rsp_next;

	// Requester holds its payload until ack
	assign sel_req = grant_data_q ? data_req_data_i : inst_req_data_i;
	assign sel_req_in = grant_data_q ? data_req_i : inst_req_i;
	// Instruction port is read only
	assign is_write = grant_data_q && sel_req.write;

	assign ar_valid_o = (state_q == ST_ADDR) && !is_write;
	assign aw_valid_o = (state_q == ST_ADDR) && is_write && !aw_done_q;
	assign w_valid_o = (state_q == ST_ADDR) && is_write && !w_done_q;
	assign r_ready_o = (state_q == ST_RESP) && !is_write;
	assign b_ready_o = (state_q == ST_RESP) && is_write;

	assign ar_o = '{addr: sel_req.addr, len: 8'd0, size: sel_req.size};
	assign aw_o = '{addr: sel_req.addr, len: 8'd0, size: sel_req.size};
	assign w_o = '{data: sel_req.wdata, strb: sel_req.wstrb, last: 1'b1};

	assign ar_fire = ar_valid_o && ar_ready_i;
	assign aw_fire = aw_valid_o && aw_ready_i;
	assign w_fire = w_valid_o && w_ready_i;
	assign resp_fire = is_write ? (b_valid_i && b_ready_o) : (r_valid_i && r_ready_o);

	assign rsp_next = is_write ? '{rdata: 32'd0, resp: b_i.resp}
		: '{rdata: r_i.data, resp: r_i.resp};

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			state_q <= ST_IDLE;
			grant_data_q <= 1'b0;
			aw_done_q <= 1'b0;
			w_done_q <= 1'b0;
			inst_ack_o <= 1'b0;
			data_ack_o <= 1'b0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					// Data port has priority
					if (data_req_i) begin
						grant_data_q <= 1'b1;
						state_q <= ST_ADDR;
					end else if (inst_req_i) begin
						grant_data_q <= 1'b0;
						state_q <= ST_ADDR;
					end
				end
				ST_ADDR: begin
					if (is_write) begin
						if (aw_fire)
							aw_done_q <= 1'b1;
						if (w_fire)
							w_done_q <= 1'b1;
						if ((aw_done_q || aw_fire) && (w_done_q || w_fire)) begin
							aw_done_q <= 1'b0;
							w_done_q <= 1'b0;
							state_q <= ST_RESP;
						end
					end else if (ar_fire) begin
						state_q <= ST_RESP;
					end
				end
				ST_RESP: begin
					if (resp_fire) begin
						state_q <= ST_DONE;
						if (grant_data_q)
							data_ack_o <= 1'b1;
						else
							inst_ack_o <= 1'b1;
					end
				end
				ST_DONE: begin
					if (!sel_req_in) begin
						inst_ack_o <= 1'b0;
						data_ack_o <= 1'b0;
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (resp_fire) begin
			if (grant_data_q)
				data_rsp_o <= rsp_next;
			else
				inst_rsp_o <= rsp_next;
		end
	end

endmodule

//--- xbar/axi_xbar.sv
`include "soc_config.svh"

module axi_xbar import soc_pkg::*; (
	input  logic clock,
	input  logic rst_n_i,
	input  logic s_ar_valid_i,
	output logic s_ar_ready_o,
	input  ar_t  s_ar_i,
	output logic s_r_valid_o,
	input  logic s_r_ready_i,
	output r_t   s_r_o,
	input  logic s_aw_valid_i,
	output logic s_aw_ready_o,
	input  aw_t  s_aw_i,
	input  logic s_w_valid_i,
	output logic s_w_ready_o,
	input  w_t   s_w_i,
	output logic s_b_valid_o,
	input  logic s_b_ready_i,
	output b_t   s_b_o,
	output logic m_ar_valid_o,
	input  logic m_ar_ready_i,
	output ar_t  m_ar_o,
	input  logic m_r_valid_i,
	output logic m_r_ready_o,
	input  r_t   m_r_i,
	output logic m_aw_valid_o,
	input  logic m_aw_ready_i,
	output aw_t  m_aw_o,
	output logic m_w_valid_o,
	input  logic m_w_ready_i,
	output w_t   m_w_o,
	input  logic m_b_valid_i,
	output logic m_b_ready_o,
	input  b_t   m_b_i,
	output logic c_ar_valid_o,
	input  logic c_ar_ready_i,
	output ar_t  c_ar_o,
	input  logic c_r_valid_i,
	output logic c_r_ready_o,
	input  r_t   c_r_i
);

	logic rd_busy_q;
	logic rd_clint_q;
	logic wr_busy_q;
	logic wr_clint_q;
	logic err_w_q;
	logic err_bvalid_q;

	logic rd_hit;
	logic wr_hit;
	logic w_clint;
	logic ar_fire;
	logic r_fire;
	logic aw_fire;
	logic w_fire;
	logic b_fire;
	logic clint_aw_done;
	logic clint_w_done;

	assign rd_hit = s_ar_i.addr.f.base == `CLINT_BASE_HI;
	assign wr_hit = s_aw_i.addr.f.base == `CLINT_BASE_HI;
	// W follows the registered AW route once AW has gone
	assign w_clint = wr_busy_q ? wr_clint_q : wr_hit;

	// Read path
	assign m_ar_valid_o = s_ar_valid_i && !rd_hit;
	assign c_ar_valid_o = s_ar_valid_i && rd_hit;
	assign s_ar_ready_o = rd_hit ? c_ar_ready_i : m_ar_ready_i;
	assign m_ar_o = s_ar_i;
	assign c_ar_o = s_ar_i;

	assign s_r_valid_o = rd_busy_q && (rd_clint_q ? c_r_valid_i : m_r_valid_i);
	assign s_r_o = rd_clint_q ? c_r_i : m_r_i;
	assign m_r_ready_o = rd_busy_q && !rd_clint_q && s_r_ready_i;
	assign c_r_ready_o = rd_busy_q && rd_clint_q && s_r_ready_i;

	// Write path with CLINT writes absorbed locally
	assign m_aw_valid_o = s_aw_valid_i && !wr_hit;
	assign s_aw_ready_o = wr_hit ? !err_bvalid_q : m_aw_ready_i;
	assign m_aw_o = s_aw_i;

	assign m_w_valid_o = s_w_valid_i && !w_clint;
	assign s_w_ready_o = w_clint ? !err_bvalid_q : m_w_ready_i;
	assign m_w_o = s_w_i;

	assign s_b_valid_o = wr_busy_q && (wr_clint_q ? err_bvalid_q : m_b_valid_i);
	assign s_b_o = wr_clint_q ? b_t'{resp: `RESP_SLVERR} : m_b_i;
	assign m_b_ready_o = wr_busy_q && !wr_clint_q && s_b_ready_i;

	assign ar_fire = s_ar_valid_i && s_ar_ready_o;
	assign r_fire = s_r_valid_o && s_r_ready_i;
	assign aw_fire = s_aw_valid_i && s_aw_ready_o;
	assign w_fire = s_w_valid_i && s_w_ready_o;
	assign b_fire = s_b_valid_o && s_b_ready_i;

	assign clint_aw_done = (wr_busy_q && wr_clint_q) || (aw_fire && wr_hit);
	assign clint_w_done = err_w_q || (w_fire && w_clint);

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			rd_busy_q <= 1'b0;
			rd_clint_q <= 1'b0;
		end else if (ar_fire) begin
			rd_busy_q <= 1'b1;
			rd_clint_q <= rd_hit;
		end else if (r_fire) begin
			rd_busy_q <= 1'b0;
			rd_clint_q <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			wr_busy_q <= 1'b0;
			wr_clint_q <= 1'b0;
			err_w_q <= 1'b0;
			err_bvalid_q <= 1'b0;
		end else begin
			if (aw_fire) begin
				wr_busy_q <= 1'b1;
				wr_clint_q <= wr_hit;
			end else if (b_fire) begin
				wr_busy_q <= 1'b0;
				wr_clint_q <= 1'b0;
			end

			if (w_fire && w_clint)
				err_w_q <= 1'b1;

			// Error response once both halves of a CLINT write are in
			if (clint_aw_done && clint_w_done && !err_bvalid_q) begin
				err_bvalid_q <= 1'b1;
				err_w_q <= 1'b0;
			end else if (b_fire) begin
				err_bvalid_q <= 1'b0;
			end
		end
	end

endmodule

//--- logic/clint.sv
`include "soc_config.svh"

module clint import soc_pkg::*; (
	input  logic clock,
	input  logic rst_n_i,
	input  logic ar_valid_i,
	output logic ar_ready_o,
	input  ar_t  ar_i,
	output logic r_valid_o,
	input  logic r_ready_i,
	output r_t   r_o
);

	localparam int PRE_W = $clog2(`MTIME_DIV + 1);

	logic [PRE_W-1:0] pre_q;
	logic [63:0] mtime_q;
	logic [31:0] rdata_q;
	logic [1:0] rresp_q;

	always_ff @(posedge clock) begin
		if (!rst_n_i) begin
			pre_q <= '0;
			mtime_q <= 64'd0;
		end else if (pre_q == PRE_W'(`MTIME_DIV - 1)) begin
			pre_q <= '0;
			mtime_q <= mtime_q + 64'd1;
		end else begin
			pre_q <= pre_q + 1'b1;
		end
	end

	// One read outstanding so AR is accepted only when idle
	assign ar_ready_o = !r_valid_o;

	always_ff @(posedge clock) begin
		if (!rst_n_i)
			r_valid_o <= 1'b0;
		else if (ar_valid_i && ar_ready_o)
			r_valid_o <= 1'b1;
		else if (r_ready_i)
			r_valid_o <= 1'b0;
	end

	always_ff @(posedge clock) begin
		if (ar_valid_i && ar_ready_o) begin
			case (ar_i.addr.f.offset)
				16'h0000: begin
					rdata_q <= mtime_q[31:0];
					rresp_q <= `RESP_OKAY;
				end
				16'h0004: begin
					rdata_q <= mtime_q[63:32];
					rresp_q <= `RESP_OKAY;
				end
				default: begin
					rdata_q <= 32'd0;
					rresp_q <= `RESP_SLVERR;
				end
			endcase
		end
	end

	assign r_o = '{data: rdata_q, resp: rresp_q, last: 1'b1};

endmodule

//--- logic/mem_subsys.sv
`include "soc_config.svh"

module mem_subsys import soc_pkg::*; (
	input  logic       clock,
	input  logic       rst_n_i,
	input  logic       inst_req_i,
	input  cpu_req_t   inst_req_data_i,
	output logic       inst_ack_o,
	output cpu_rsp_t   inst_rsp_o,
	input  logic       data_req_i,
	input  cpu_req_t   data_req_data_i,
	output logic       data_ack_o,
	output cpu_rsp_t   data_rsp_o,
	output logic       m_ar_valid_o,
	input  logic       m_ar_ready_i,
	output ar_t        m_ar_o,
	output logic [1:0] m_ar_burst_o,
	input  logic       m_r_valid_i,
	output logic       m_r_ready_o,
	input  r_t         m_r_i,
	output logic       m_aw_valid_o,
	input  logic       m_aw_ready_i,
	output aw_t        m_aw_o,
	output logic [1:0] m_aw_burst_o,
	output logic       m_w_valid_o,
	input  logic       m_w_ready_i,
	output w_t         m_w_o,
	input  logic       m_b_valid_i,
	output logic       m_b_ready_o,
	input  b_t         m_b_i
);

	// Controller to crossbar
	logic x_ar_valid, x_ar_ready, x_r_valid, x_r_ready;
	logic x_aw_valid, x_aw_ready, x_w_valid, x_w_ready;
	logic x_b_valid, x_b_ready;
	ar_t x_ar;
	r_t x_r;
	aw_t x_aw;
	w_t x_w;
	b_t x_b;

	// Crossbar to CLINT
	logic c_ar_valid, c_ar_ready, c_r_valid, c_r_ready;
	ar_t c_ar;
	r_t c_r;

	assign m_ar_burst_o = `AXI_ADDR_BURST_INCR;
	assign m_aw_burst_o = `AXI_ADDR_BURST_INCR;

	axi_ctl u_axi_ctl (
		.clock           (clock),
		.rst_n_i         (rst_n_i),
		.inst_req_i      (inst_req_i),
		.inst_req_data_i (inst_req_data_i),
		.inst_ack_o      (inst_ack_o),
		.inst_rsp_o      (inst_rsp_o),
		.data_req_i      (data_req_i),
		.data_req_data_i (data_req_data_i),
		.data_ack_o      (data_ack_o),
		.data_rsp_o      (data_rsp_o),
		.ar_valid_o      (x_ar_valid),
		.ar_ready_i      (x_ar_ready),
		.ar_o            (x_ar),
		.r_valid_i       (x_r_valid),
		.r_ready_o       (x_r_ready),
		.r_i             (x_r),
		.aw_valid_o      (x_aw_valid),
		.aw_ready_i      (x_aw_ready),
		.aw_o            (x_aw),
		.w_valid_o       (x_w_valid),
		.w_ready_i       (x_w_ready),
		.w_o             (x_w),
		.b_valid_i       (x_b_valid),
		.b_ready_o       (x_b_ready),
		.b_i             (x_b)
	);

	axi_xbar u_axi_xbar (
		.clock        (clock),
		.rst_n_i      (rst_n_i),
		.s_ar_valid_i (x_ar_valid),
		.s_ar_ready_o (x_ar_ready),
		.s_ar_i       (x_ar),
		.s_r_valid_o  (x_r_valid),
		.s_r_ready_i  (x_r_ready),
		.s_r_o        (x_r),
		.s_aw_valid_i (x_aw_valid),
		.s_aw_ready_o (x_aw_ready),
		.s_aw_i       (x_aw),
		.s_w_valid_i  (x_w_valid),
		.s_w_ready_o  (x_w_ready),
		.s_w_i        (x_w),
		.s_b_valid_o  (x_b_valid),
		.s_b_ready_i  (x_b_ready),
		.s_b_o        (x_b),
		.m_ar_valid_o (m_ar_valid_o),
		.m_ar_ready_i (m_ar_ready_i),
		.m_ar_o       (m_ar_o),
		.m_r_valid_i  (m_r_valid_i),
		.m_r_ready_o  (m_r_ready_o),
		.m_r_i        (m_r_i),
		.m_aw_valid_o (m_aw_valid_o),
		.m_aw_ready_i (m_aw_ready_i),
		.m_aw_o       (m_aw_o),
		.m_w_valid_o  (m_w_valid_o),
		.m_w_ready_i  (m_w_ready_i),
		.m_w_o        (m_w_o),
		.m_b_valid_i  (m_b_valid_i),
		.m_b_ready_o  (m_b_ready_o),
		.m_b_i        (m_b_i),
		.c_ar_valid_o (c_ar_valid),
		.c_ar_ready_i (c_ar_ready),
		.c_ar_o       (c_ar),
		.c_r_valid_i  (c_r_valid),
		.c_r_ready_o  (c_r_ready),
		.c_r_i        (c_r)
	);

	clint u_clint (
		.clock      (clock),
		.rst_n_i    (rst_n_i),
		.ar_valid_i (c_ar_valid),
		.ar_ready_o (c_ar_ready),
		.ar_i       (c_ar),
		.r_valid_o  (c_r_valid),
		.r_ready_i  (c_r_ready),
		.r_o        (c_r)
	);

endmodule

//--- tests/mem_subsys_props.sv
module mem_subsys_props import soc_pkg::*; (
	input logic clock,
	input logic rst_n_i,
	input logic ar_valid_i,
	input logic ar_ready_i,
	input ar_t  ar_i,
	input logic aw_valid_i,
	input logic aw_ready_i,
	input aw_t  aw_i,
	input logic inst_req_i,
	input logic inst_ack_i,
	input logic data_req_i,
	input logic data_ack_i
);

	int unsigned fail_count = 0;

	// External address channels hold until accepted
	ar_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
		else begin
			fail_count++;
			$error("External AR valid or payload changed before ready");
		end

	aw_hold: assert property (@(posedge clock) disable iff (!rst_n_i)
		aw_valid_i && !aw_ready_i |=> aw_valid_i && $stable(aw_i))
		else begin
			fail_count++;
			$error("External AW valid or payload changed before ready");
		end

	inst_ack_rise: assert property (@(posedge clock) disable iff (!rst_n_i)
		$rose(inst_ack_i) |-> inst_req_i)
		else begin
			fail_count++;
			$error("Instruction ack rose without a request");
		end

	data_ack_rise: assert property (@(posedge clock) disable iff (!rst_n_i)
		$rose(data_ack_i) |-> data_req_i)
		else begin
			fail_count++;
			$error("Data ack rose without a request");
		end

	ack_onehot: assert property (@(posedge clock) disable iff (!rst_n_i)
		!(inst_ack_i && data_ack_i))
		else begin
			fail_count++;
			$error("Both acks high together");
		end

endmodule

bind mem_subsys mem_subsys_props u_props (
	.clock      (clock),
	.rst_n_i    (rst_n_i),
	.ar_valid_i (m_ar_valid_o),
	.ar_ready_i (m_ar_ready_i),
	.ar_i       (m_ar_o),
	.aw_valid_i (m_aw_valid_o),
	.aw_ready_i (m_aw_ready_i),
	.aw_i       (m_aw_o),
	.inst_req_i (inst_req_i),
	.inst_ack_i (inst_ack_o),
	.data_req_i (data_req_i),
	.data_ack_i (data_ack_o)
);

//--- tests/mem_subsys_tb.sv
`include "soc_config.svh"

module mem_subsys_tb import soc_pkg::*; ();

	logic clock;
	logic rst_n_i;
	logic inst_req_i;
	cpu_req_t inst_req_data_i;
	logic inst_ack_o;
	cpu_rsp_t inst_rsp_o;
	logic data_req_i;
	cpu_req_t data_req_data_i;
	logic data_ack_o;
	cpu_rsp_t data_rsp_o;
	logic m_ar_valid_o;
	logic m_ar_ready_i;
	ar_t m_ar_o;
	logic [1:0] m_ar_burst_o;
	logic m_r_valid_i;
	logic m_r_ready_o;
	r_t m_r_i;
	logic m_aw_valid_o;
	logic m_aw_ready_i;
	aw_t m_aw_o;
	logic [1:0] m_aw_burst_o;
	logic m_w_valid_o;
	logic m_w_ready_i;
	w_t m_w_o;
	logic m_b_valid_i;
	logic m_b_ready_o;
	b_t m_b_i;

	// Vector table
	logic v_data[64];
	logic v_write[64];
	logic v_par[64];
	logic [31:0] v_addr[64];
	logic [31:0] v_wdata[64];
	logic [3:0] v_wstrb[64];
	logic [31:0] v_rdata[64];
	logic [1:0] v_resp[64];
	int nvec;
	int limit_cycles;
	int errors;
	int checks;
	string cur_name;

	// Unwritten external memory words read as the inverted address
	logic [31:0] mem_addr[$];
	logic [31:0] mem_data[$];
	logic [31:0] ar_log[$];
	int aw_count;

	int mtime_reads;
	logic [31:0] first_mtime;
	logic [31:0] last_mtime;

	mem_subsys dut (.*);

	always #4 clock = ~clock;

	task automatic step();
		@(posedge clock);
		#1;
	endtask

	task automatic random_wait();
		repeat ($urandom % 4)
			step();
	endtask

	function automatic void check_field(input string what, input logic [31:0] act,
		input logic [31:0] exp);
		if (act !== exp) begin
			errors++;
			$display("Error: %s %s expected %h actual %h", cur_name, what, exp, act);
		end
	endfunction

	function automatic logic [31:0] mem_read(input logic [31:0] a);
		int k;
		for (k = 0; k < mem_addr.size(); k++)
			if (mem_addr[k] == a)
				return mem_data[k];
		return ~a;
	endfunction

	function automatic void mem_write(input logic [31:0] a, input logic [31:0] d,
		input logic [3:0] strb);
		logic [31:0] w;
		int k;
		w = mem_read(a);
		for (k = 0; k < 4; k++)
			if (strb[k])
				w[8*k +: 8] = d[8*k +: 8];
		for (k = 0; k < mem_addr.size(); k++) begin
			if (mem_addr[k] == a) begin
				mem_data[k] = w;
				return;
			end
		end
		mem_addr.push_back(a);
		mem_data.push_back(w);
	endfunction

	task automatic start_req(input int k);
		cpu_req_t r;
		r.addr.raw = v_addr[k];
		r.write = v_write[k];
		r.wdata = v_wdata[k];
		r.wstrb = v_wstrb[k];
		r.size = 3'd2;
		if (v_data[k]) begin
			data_req_data_i = r;
			data_req_i = 1'b1;
		end else begin
			inst_req_data_i = r;
			inst_req_i = 1'b1;
		end
	endtask

	// Wait for ack, take the response, then close the four-phase handshake
	task automatic finish_req(input logic is_data, output cpu_rsp_t rsp);
		@(negedge clock);
		while (!(is_data ? data_ack_o : inst_ack_o))
			@(negedge clock);
		rsp = is_data ? data_rsp_o : inst_rsp_o;
		step();
		if (is_data)
			data_req_i = 1'b0;
		else
			inst_req_i = 1'b0;
		@(negedge clock);
		while (is_data ? data_ack_o : inst_ack_o)
			@(negedge clock);
		step();
	endtask

	task automatic check_txn(input int k, input cpu_rsp_t rsp, input int ar0, input int aw0);
		string name;
		logic [31:0] a;
		name = $sformatf("vec%0d", k);
		a = v_addr[k];
		checks++;
		if (rsp.resp !== v_resp[k]) begin
			errors++;
			$display("Error: %s resp expected %0d actual %0d", name, v_resp[k], rsp.resp);
		end
		if (a[31:16] == `CLINT_BASE_HI && a[15:0] == 16'h0 && !v_write[k]) begin
			// mtime low word only has to move forward
			if (mtime_reads > 0 && rsp.rdata < last_mtime) begin
				errors++;
				$display("Error: %s mtime expected at least %h actual %h",
					name, last_mtime, rsp.rdata);
			end
			if (mtime_reads == 0)
				first_mtime = rsp.rdata;
			last_mtime = rsp.rdata;
			mtime_reads++;
		end else if (rsp.rdata !== v_rdata[k]) begin
			errors++;
			$display("Error: %s rdata expected %h actual %h", name, v_rdata[k], rsp.rdata);
		end
		if (a[31:16] == `CLINT_BASE_HI && (ar_log.size() != ar0 || aw_count != aw0)) begin
			errors++;
			$display("%s: CLINT access showed up on the external AXI port", name);
		end
	endtask

	task automatic serve_reads();
		logic [31:0] a;
		forever begin
			random_wait();
			m_ar_ready_i = 1'b1;
			@(negedge clock);
			while (!m_ar_valid_o)
				@(negedge clock);
			a = m_ar_o.addr.raw & 32'hffff_fffc;
			check_field("AR burst", m_ar_burst_o, `AXI_ADDR_BURST_INCR);
			check_field("AR len", m_ar_o.len, 8'd0);
			check_field("AR size", m_ar_o.size, 3'd2);
			step();
			m_ar_ready_i = 1'b0;
			ar_log.push_back(a);
			random_wait();
			if (a >= 32'h8fff_0000)
				m_r_i = '{data: 32'd0, resp: `RESP_SLVERR, last: 1'b1};
			else
				m_r_i = '{data: mem_read(a), resp: `RESP_OKAY, last: 1'b1};
			m_r_valid_i = 1'b1;
			@(negedge clock);
			while (!m_r_ready_o)
				@(negedge clock);
			step();
			m_r_valid_i = 1'b0;
		end
	endtask

	task automatic serve_writes();
		logic [31:0] a;
		logic [31:0] d;
		logic [3:0] s;
		forever begin
			fork
				begin
					random_wait();
					m_aw_ready_i = 1'b1;
					@(negedge clock);
					while (!m_aw_valid_o)
						@(negedge clock);
					a = m_aw_o.addr.raw & 32'hffff_fffc;
					check_field("AW burst", m_aw_burst_o, `AXI_ADDR_BURST_INCR);
					check_field("AW len", m_aw_o.len, 8'd0);
					check_field("AW size", m_aw_o.size, 3'd2);
					step();
					m_aw_ready_i = 1'b0;
				end
				begin
					random_wait();
					m_w_ready_i = 1'b1;
					@(negedge clock);
					while (!m_w_valid_o)
						@(negedge clock);
					d = m_w_o.data;
					s = m_w_o.strb;
					check_field("W last", m_w_o.last, 1'b1);
					step();
					m_w_ready_i = 1'b0;
				end
			join
			aw_count++;
			random_wait();
			if (a >= 32'h8fff_0000) begin
				m_b_i.resp = `RESP_SLVERR;
			end else begin
				mem_write(a, d, s);
				m_b_i.resp = `RESP_OKAY;
			end
			m_b_valid_i = 1'b1;
			@(negedge clock);
			while (!m_b_ready_o)
				@(negedge clock);
			step();
			m_b_valid_i = 1'b0;
		end
	endtask

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles)
			@(posedge clock);
		$display("Timeout: vectors did not complete within %0d cycles", limit_cycles);
		$display("Errors found");
		$finish;
	end

	initial begin : main
		int fd;
		int n;
		int i;
		int par;
		int ar0;
		int aw0;
		string line;
		string ps;
		string os;
		logic [31:0] a;
		logic [31:0] wd;
		logic [31:0] rd;
		logic [3:0] ws;
		logic [1:0] rs;
		cpu_rsp_t rsp;

		void'($urandom(32'hdd25b1ed));
		clock = 1'b0;
		rst_n_i = 1'b0;
		inst_req_i = 1'b0;
		inst_req_data_i = '0;
		data_req_i = 1'b0;
		data_req_data_i = '0;
		m_ar_ready_i = 1'b0;
		m_r_valid_i = 1'b0;
		m_r_i = '0;
		m_aw_ready_i = 1'b0;
		m_w_ready_i = 1'b0;
		m_b_valid_i = 1'b0;
		m_b_i = '0;
		nvec = 0;
		limit_cycles = 0;
		errors = 0;
		checks = 0;
		aw_count = 0;
		mtime_reads = 0;
		cur_name = "reset";

		fd = $fopen("tests/mem_subsys_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Vector file tests/mem_subsys_vectors.txt could not be opened");
		end else begin
			while ($fgets(line, fd) > 0) begin
				n = $sscanf(line, "%s %s %h %h %h %h %h %d", ps, os, a, wd, ws, rd, rs, par);
				if (n == 8 && nvec < 64) begin
					v_data[nvec] = (ps == "D");
					v_write[nvec] = (os == "W");
					v_addr[nvec] = a;
					v_wdata[nvec] = wd;
					v_wstrb[nvec] = ws;
					v_rdata[nvec] = rd;
					v_resp[nvec] = rs;
					v_par[nvec] = (par != 0);
					nvec++;
				end
			end
			$fclose(fd);
			limit_cycles = nvec * 64 + 200;
		end

		repeat (10)
			@(posedge clock);
		#1;
		rst_n_i = 1'b1;
		// External slave models draw their delays from the seeded stream
		fork
			serve_reads();
			serve_writes();
		join_none
		step();

		i = 0;
		while (i < nvec) begin
			if (v_par[i] && i + 1 < nvec)
				cur_name = $sformatf("vec%0d-%0d", i, i + 1);
			else
				cur_name = $sformatf("vec%0d", i);
			ar0 = ar_log.size();
			aw0 = aw_count;
			start_req(i);
			if (v_par[i] && i + 1 < nvec) begin
				// Both ports raise req in the same cycle and data goes first
				start_req(i + 1);
				finish_req(v_data[i], rsp);
				check_txn(i, rsp, ar0, aw0);
				if (ar_log.size() == ar0 || ar_log[ar0] !== v_addr[i]) begin
					errors++;
					$display("Error: vec%0d first AR address expected %h actual %h", i,
						v_addr[i], (ar_log.size() > ar0) ? ar_log[ar0] : 32'hx);
				end
				finish_req(v_data[i + 1], rsp);
				check_txn(i + 1, rsp, ar0, aw0);
				i = i + 2;
			end else begin
				finish_req(v_data[i], rsp);
				check_txn(i, rsp, ar0, aw0);
				i = i + 1;
			end
		end

		if (mtime_reads >= 2 && last_mtime == first_mtime) begin
			errors++;
			$display("mtime did not advance over %0d reads", mtime_reads);
		end

		errors = errors + dut.u_props.fail_count;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

//--- tests/mem_subsys_vectors.txt
# port(I/D) op(R/W) addr wdata wstrb exp_rdata exp_resp par
# par 1 issues the line together with the next one; rdata of CLINT offset 0 reads is unchecked
I R 80000000 00000000 0 7fffffff 0 0
I R 80000004 00000000 0 7ffffffb 0 0
D R 02000000 00000000 0 00000000 0 0
D W 80000010 11223344 5 00000000 0 0
D R 80000010 00000000 0 7f22ff44 0 0
D W 80000020 aabbccdd f 00000000 0 0
I R 80000020 00000000 0 aabbccdd 0 0
D R 80000100 00000000 0 7ffffeff 0 1
I R 80000200 00000000 0 7ffffdff 0 0
I R 02000004 00000000 0 00000000 0 0
D R 02000000 00000000 0 00000000 0 0
D W 02000000 12345678 f 00000000 2 0
D R 02000008 00000000 0 00000000 2 0
D R 90000000 00000000 0 00000000 2 0
I R 8fff0000 00000000 0 00000000 2 0
D W 8fff0004 deadbeef f 00000000 2 0
D W 80000024 cafef00d 8 00000000 0 0
D R 80000024 00000000 0 caffffdb 0 0
I R 02000000 00000000 0 00000000 0 0

//--- project.f
+incdir+common
common/soc_pkg.sv
axi_ctl/axi_ctl.sv
xbar/axi_xbar.sv
logic/clint.sv
logic/mem_subsys.sv
tests/mem_subsys_props.sv
tests/mem_subsys_tb.sv
